// File: nebula_ctrl_top.f
src/nebula_pkg.sv
src/nebula_config_regs.sv
src/nebula_status_agg.sv
src/nebula_trace_capture.sv
src/nebula_ctrl_top.sv
tests/nebula_ctrl_assertions.sv
tests/tb_nebula_ctrl.sv

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it and judge the log
set -e

cd "$(dirname "$0")"

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_nebula_ctrl \
  -f nebula_ctrl_top.f \
  --Mdir "$BUILD_DIR"

# The log decides the result, so a fatal exit must not stop the script here
"./$BUILD_DIR/Vtb_nebula_ctrl" > "$LOG_FILE" 2>&1 || true
cat "$LOG_FILE"

if grep -q "^Testbench passed$" "$LOG_FILE"; then
  echo "Simulation result: PASS"
else
  echo "Simulation result: FAIL"
  exit 1
fi

// File: tests/tb_nebula_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module tb_nebula_ctrl
  import nebula_pkg::*;
();

  localparam int MESH_WIDTH       = 2;
  localparam int MESH_HEIGHT      = 3;
  localparam int NUM_NODES        = MESH_WIDTH * MESH_HEIGHT;
  localparam int CLK_PERIOD       = 20;
  localparam int RESET_CYCLES     = 5;
  localparam int CYCLES_PER_ENTRY = 50;
  localparam int MAX_ENTRIES      = 24;

  typedef enum {KIND_CFG, KIND_ERR, KIND_TRACE} entry_kind_t;

  // pat_a and pat_b hold router/protocol errors or local valid/ready
  typedef struct {
    entry_kind_t          kind;
    cfg_addr_t            addr;
    logic                 write;
    cfg_data_t            wdata;
    cfg_data_t            exp_data;
    logic                 exp_flag;
    int                   hold;
    logic [NUM_NODES-1:0] pat_a;
    logic [NUM_NODES-1:0] pat_b;
    node_id_t             exp_node;
  } entry_t;

  logic                            clk;
  logic                            rst_n;
  logic                            cfg_req_valid;
  logic                            cfg_req_ready;
  cfg_addr_t                       cfg_req_addr;
  cfg_data_t                       cfg_req_data;
  logic                            cfg_req_write;
  logic                            cfg_resp_valid;
  logic                            cfg_resp_ready;
  cfg_data_t                       cfg_resp_data;
  logic                            cfg_resp_error;
  logic [NUM_NODES-1:0]            router_error;
  logic [NUM_NODES-1:0]            protocol_error;
  status_word_t                    system_status;
  status_word_t                    error_status;
  logic [NUM_NODES-1:0]            local_valid;
  logic [NUM_NODES-1:0]            local_ready;
  flit_header_t [NUM_NODES-1:0]    local_header;
  flit_payload_t [NUM_NODES-1:0]   local_payload;
  logic                            trace_valid;
  trace_data_t                     trace_data;
  node_id_t                        trace_node_id;

  entry_t               entries [MAX_ENTRIES];
  string                entry_name [MAX_ENTRIES];
  int                   n_entries = 0;
  logic [NUM_NODES-1:0] err_flags_model = '0;
  trace_data_t          trace_exp_data = '0;
  node_id_t             trace_exp_node = '0;

  nebula_ctrl_top #(
    .MESH_WIDTH  (MESH_WIDTH),
    .MESH_HEIGHT (MESH_HEIGHT),
    .ENABLE_AXI  (1'b1),
    .ENABLE_CHI  (1'b0)
  ) dut0 (.*);

  // ==================================================
  // Clock and watchdog
  // ==================================================

  initial clk = 1'b0;
  always #(CLK_PERIOD/2) clk = ~clk;

  initial begin
    #1;
    #((RESET_CYCLES + CYCLES_PER_ENTRY * n_entries) * CLK_PERIOD);
    stop_on_error("Watchdog expired before all table entries were applied");
  end

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("Testbench failed");
    $fatal(1, "Run stopped at the first error");
  endtask

  // ==================================================
  // Compare tasks
  // ==================================================

  task automatic check_cfg_data(input string name, input cfg_data_t exp, input cfg_data_t act);
    if (act !== exp) begin
      stop_on_error($sformatf("Fail %s: expected %h, actual %h", name, exp, act));
    end
  endtask

  task automatic check_status(input string name, input status_word_t exp,
                              input status_word_t act);
    if (act !== exp) begin
      stop_on_error($sformatf("Fail %s: expected %h, actual %h", name, exp, act));
    end
  endtask

  task automatic check_trace(input string name, input trace_data_t exp_data,
                             input node_id_t exp_node, input trace_data_t act_data,
                             input node_id_t act_node);
    if (act_data !== exp_data) begin
      stop_on_error($sformatf("Fail %s data: expected %h, actual %h", name, exp_data, act_data));
    end
    if (act_node !== exp_node) begin
      stop_on_error($sformatf("Fail %s node: expected %0d, actual %0d", name, exp_node, act_node));
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      stop_on_error($sformatf("Fail %s: expected %b, actual %b", name, exp, act));
    end
  endtask

  // Bit 13 comes from the flags of the previous cycle
  function automatic status_word_t expected_error_status(input logic [NUM_NODES-1:0] perr,
      input logic [NUM_NODES-1:0] rerr, input logic [NUM_NODES-1:0] flags);
    status_word_t s;
    s = '0;
    s[15] = |perr;
    s[14] = |rerr;
    s[13] = |flags;
    return s;
  endfunction

  // ==================================================
  // Table entries
  // ==================================================

  task automatic cfg_entry(input string name, input cfg_addr_t addr, input logic write,
                           input cfg_data_t wdata, input cfg_data_t exp_data,
                           input logic exp_error, input int hold);
    entry_name[n_entries]        = name;
    entries[n_entries].kind      = KIND_CFG;
    entries[n_entries].addr      = addr;
    entries[n_entries].write     = write;
    entries[n_entries].wdata     = wdata;
    entries[n_entries].exp_data  = exp_data;
    entries[n_entries].exp_flag  = exp_error;
    entries[n_entries].hold      = hold;
    n_entries++;
  endtask

  task automatic error_entry(input string name, input logic [NUM_NODES-1:0] rerr,
                             input logic [NUM_NODES-1:0] perr);
    entry_name[n_entries]    = name;
    entries[n_entries].kind  = KIND_ERR;
    entries[n_entries].pat_a = rerr;
    entries[n_entries].pat_b = perr;
    n_entries++;
  endtask

  task automatic delivery_entry(input string name, input logic [NUM_NODES-1:0] valid,
                                input logic [NUM_NODES-1:0] ready, input logic hit,
                                input node_id_t node);
    entry_name[n_entries]       = name;
    entries[n_entries].kind     = KIND_TRACE;
    entries[n_entries].pat_a    = valid;
    entries[n_entries].pat_b    = ready;
    entries[n_entries].exp_flag = hit;
    entries[n_entries].exp_node = node;
    n_entries++;
  endtask

  task automatic build_table();
    cfg_data_t wr_word;
    wr_word = $urandom();
    // Topology defaults for a 2 by 3 mesh with CHI off
    cfg_entry("read topology", 16'h0000, 1'b0, '0, 32'h0000_0302, 1'b0, 0);
    cfg_entry("read chi enable", 16'h0001, 1'b0, '0, 32'h0, 1'b0, 0);
    cfg_entry("read axi enable", 16'h0002, 1'b0, '0, 32'h1, 1'b0, 0);
    cfg_entry("read node count", 16'h0003, 1'b0, '0, 32'h6, 1'b0, 0);
    cfg_entry("read unused 200", 16'd200, 1'b0, '0, 32'h0, 1'b0, 0);
    cfg_entry("write reg 40", 16'd40, 1'b1, wr_word, 32'h0, 1'b0, 0);
    cfg_entry("read reg 40", 16'd40, 1'b0, '0, wr_word, 1'b0, 0);
    cfg_entry("read reg 40 upper bits", 16'hA528, 1'b0, '0, wr_word, 1'b0, 0);
    cfg_entry("write read-only 2", 16'h0002, 1'b1, ~wr_word, 32'h0, 1'b1, 0);
    cfg_entry("read-only 2 kept", 16'h0002, 1'b0, '0, 32'h1, 1'b0, 0);
    cfg_entry("stalled read 40", 16'd40, 1'b0, '0, wr_word, 1'b0, 4);
    cfg_entry("read after release", 16'h0003, 1'b0, '0, 32'h6, 1'b0, 0);
    error_entry("router error node 2", 6'b000100, 6'b000000);
    error_entry("protocol error node 5", 6'b000000, 6'b100000);
    error_entry("both errors", 6'b010001, 6'b000010);
    error_entry("errors cleared", 6'b000000, 6'b000000);
    delivery_entry("deliveries at 3 and 5", 6'b101000, 6'b101000, 1'b1, 8'd3);
    delivery_entry("valid without ready", 6'b000010, 6'b000000, 1'b0, 8'd0);
  endtask

  // ==================================================
  // Entry drivers
  // ==================================================

  task automatic do_cfg_access(input int idx);
    entry_t e;
    string  name;
    e    = entries[idx];
    name = entry_name[idx];
    @(negedge clk);
    check_flag({name, " req_ready"}, 1'b1, cfg_req_ready);
    cfg_req_valid  = 1'b1;
    cfg_req_addr   = e.addr;
    cfg_req_data   = e.wdata;
    cfg_req_write  = e.write;
    cfg_resp_ready = (e.hold == 0);
    // Response is due exactly one cycle after acceptance
    @(negedge clk);
    cfg_req_valid = 1'b0;
    check_flag({name, " resp_valid"}, 1'b1, cfg_resp_valid);
    for (int i = 0; i < e.hold; i++) begin
      check_flag({name, " req_ready stalled"}, 1'b0, cfg_req_ready);
      check_cfg_data({name, " stalled"}, e.exp_data, cfg_resp_data);
      @(negedge clk);
      check_flag({name, " resp_valid stalled"}, 1'b1, cfg_resp_valid);
    end
    check_cfg_data(name, e.exp_data, cfg_resp_data);
    check_flag({name, " resp_error"}, e.exp_flag, cfg_resp_error);
    cfg_resp_ready = 1'b1;
  endtask

  task automatic drive_error_pattern(input int idx);
    entry_t       e;
    status_word_t exp;
    e = entries[idx];
    @(negedge clk);
    router_error   = e.pat_a;
    protocol_error = e.pat_b;
    #(CLK_PERIOD/4);
    exp = expected_error_status(e.pat_b, e.pat_a, err_flags_model);
    check_status({entry_name[idx], " live bits"}, exp, error_status);
    @(negedge clk);
    err_flags_model = e.pat_a | e.pat_b;
    exp = expected_error_status(e.pat_b, e.pat_a, err_flags_model);
    check_status({entry_name[idx], " registered bit"}, exp, error_status);
    check_status({entry_name[idx], " system status"}, 32'h5A5A_0323, system_status);
  endtask

  task automatic drive_deliveries(input int idx);
    entry_t e;
    e = entries[idx];
    @(negedge clk);
    for (int n = 0; n < NUM_NODES; n++) begin
      local_header[n]  = $urandom();
      local_payload[n] = $urandom();
    end
    local_valid = e.pat_a;
    local_ready = e.pat_b;
    if (e.exp_flag) begin
      trace_exp_data = {local_header[e.exp_node], local_payload[e.exp_node]};
      trace_exp_node = e.exp_node;
    end
    @(negedge clk);
    local_valid = '0;
    local_ready = '0;
    check_flag({entry_name[idx], " trace_valid"}, e.exp_flag, trace_valid);
    // Without a pulse the last captured word stays
    check_trace(entry_name[idx], trace_exp_data, trace_exp_node, trace_data, trace_node_id);
  endtask

  // ==================================================
  // Main sequence
  // ==================================================

  initial begin
    void'($urandom(32'hb6d7_9899));
    rst_n          = 1'b0;
    cfg_req_valid  = 1'b0;
    cfg_req_addr   = '0;
    cfg_req_data   = '0;
    cfg_req_write  = 1'b0;
    cfg_resp_ready = 1'b1;
    router_error   = '0;
    protocol_error = '0;
    local_valid    = '0;
    local_ready    = '0;
    local_header   = '0;
    local_payload  = '0;
    build_table();
    repeat (RESET_CYCLES) @(negedge clk);
    rst_n = 1'b1;
    for (int i = 0; i < n_entries; i++) begin
      case (entries[i].kind)
        KIND_CFG: do_cfg_access(i);
        KIND_ERR: drive_error_pattern(i);
        default:  drive_deliveries(i);
      endcase
    end
    @(negedge clk);
    $display("Testbench passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: tests/nebula_ctrl_assertions.sv
`timescale 1ns/100ps
`default_nettype none

module nebula_ctrl_assertions
  import nebula_pkg::*;
#(
  parameter int NUM_NODES = 16
) (
  input logic                 clk,
  input logic                 rst_n,
  input logic                 cfg_req_ready,
  input logic                 cfg_resp_valid,
  input logic                 cfg_resp_ready,
  input cfg_data_t            cfg_resp_data,
  input logic [NUM_NODES-1:0] local_valid,
  input logic [NUM_NODES-1:0] local_ready,
  input logic                 trace_valid
);

  // ==================================================
  // Configuration response slot
  // ==================================================

  ready_follows_slot: assert property (@(posedge clk) disable iff (!rst_n)
    cfg_req_ready == (!cfg_resp_valid || cfg_resp_ready))
    else $error("cfg_req_ready does not match the response slot state");

  // Stalled response must not move
  resp_held_under_stall: assert property (@(posedge clk) disable iff (!rst_n)
    cfg_resp_valid && !cfg_resp_ready |=> cfg_resp_valid && $stable(cfg_resp_data))
    else $error("Response changed while cfg_resp_ready was low");

  // ==================================================
  // Trace
  // ==================================================

  trace_needs_delivery: assert property (@(posedge clk) disable iff (!rst_n)
    trace_valid |-> $past(|(local_valid & local_ready)))
    else $error("trace_valid without a delivery in the previous cycle");

endmodule

// Register port checks with the trace side tied idle
bind nebula_config_regs nebula_ctrl_assertions #(
  .NUM_NODES (1)
) u_cfg_assertions (
  .clk            (clk),
  .rst_n          (rst_n),
  .cfg_req_ready  (cfg_req_ready),
  .cfg_resp_valid (cfg_resp_valid),
  .cfg_resp_ready (cfg_resp_ready),
  .cfg_resp_data  (cfg_resp_data),
  .local_valid    (1'b0),
  .local_ready    (1'b0),
  .trace_valid    (1'b0)
);

// Trace checks with an always-empty response slot
bind nebula_trace_capture nebula_ctrl_assertions #(
  .NUM_NODES (NUM_NODES)
) u_trace_assertions (
  .clk            (clk),
  .rst_n          (rst_n),
  .cfg_req_ready  (1'b1),
  .cfg_resp_valid (1'b0),
  .cfg_resp_ready (1'b1),
  .cfg_resp_data  ('0),
  .local_valid    (local_valid),
  .local_ready    (local_ready),
  .trace_valid    (trace_valid)
);

`default_nettype wire

// File: src/nebula_ctrl_top.sv
`timescale 1ns/100ps
`default_nettype none

module nebula_ctrl_top
  import nebula_pkg::*;
#(
  parameter int MESH_WIDTH  = 4,
  parameter int MESH_HEIGHT = 4,
  parameter bit ENABLE_AXI  = 1'b1,
  parameter bit ENABLE_CHI  = 1'b1
) (
  input  logic                                       clk,
  input  logic                                       rst_n,

  // Configuration request and response
  input  logic                                       cfg_req_valid,
  output logic                                       cfg_req_ready,
  input  cfg_addr_t                                  cfg_req_addr,
  input  cfg_data_t                                  cfg_req_data,
  input  logic                                       cfg_req_write,
  output logic                                       cfg_resp_valid,
  input  logic                                       cfg_resp_ready,
  output cfg_data_t                                  cfg_resp_data,
  output logic                                       cfg_resp_error,

  // Per-node error levels
  input  logic [MESH_WIDTH*MESH_HEIGHT-1:0]          router_error,
  input  logic [MESH_WIDTH*MESH_HEIGHT-1:0]          protocol_error,

  // Status words
  output status_word_t                               system_status,
  output status_word_t                               error_status,

  // Local-port deliveries
  input  logic [MESH_WIDTH*MESH_HEIGHT-1:0]          local_valid,
  input  logic [MESH_WIDTH*MESH_HEIGHT-1:0]          local_ready,
  input  flit_header_t [MESH_WIDTH*MESH_HEIGHT-1:0]  local_header,
  input  flit_payload_t [MESH_WIDTH*MESH_HEIGHT-1:0] local_payload,

  // Trace
  output logic                                       trace_valid,
  output trace_data_t                                trace_data,
  output node_id_t                                   trace_node_id
);

  // ==================================================
  // Register file and topology status side by side
  // ==================================================

  nebula_config_regs #(
    .MESH_WIDTH  (MESH_WIDTH),
    .MESH_HEIGHT (MESH_HEIGHT),
    .ENABLE_AXI  (ENABLE_AXI),
    .ENABLE_CHI  (ENABLE_CHI)
  ) u_config_regs (
    .clk            (clk),
    .rst_n          (rst_n),
    .cfg_req_valid  (cfg_req_valid),
    .cfg_req_ready  (cfg_req_ready),
    .cfg_req_addr   (cfg_req_addr),
    .cfg_req_data   (cfg_req_data),
    .cfg_req_write  (cfg_req_write),
    .cfg_resp_valid (cfg_resp_valid),
    .cfg_resp_ready (cfg_resp_ready),
    .cfg_resp_data  (cfg_resp_data),
    .cfg_resp_error (cfg_resp_error)
  );

  nebula_status_agg #(
    .MESH_WIDTH  (MESH_WIDTH),
    .MESH_HEIGHT (MESH_HEIGHT),
    .ENABLE_AXI  (ENABLE_AXI),
    .ENABLE_CHI  (ENABLE_CHI)
  ) u_status_agg (
    .clk            (clk),
    .rst_n          (rst_n),
    .router_error   (router_error),
    .protocol_error (protocol_error),
    .system_status  (system_status),
    .error_status   (error_status)
  );

  // Delivery trace
  nebula_trace_capture #(
    .MESH_WIDTH  (MESH_WIDTH),
    .MESH_HEIGHT (MESH_HEIGHT)
  ) u_trace_capture (
    .clk           (clk),
    .rst_n         (rst_n),
    .local_valid   (local_valid),
    .local_ready   (local_ready),
    .local_header  (local_header),
    .local_payload (local_payload),
    .trace_valid   (trace_valid),
    .trace_data    (trace_data),
    .trace_node_id (trace_node_id)
  );

endmodule

`default_nettype wire

// File: src/nebula_trace_capture.sv
`timescale 1ns/100ps
`default_nettype none

module nebula_trace_capture
  import nebula_pkg::*;
#(
  parameter int MESH_WIDTH  = 4,
  parameter int MESH_HEIGHT = 4
) (
  input  logic                                       clk,
  input  logic                                       rst_n,

  // Local-port output handshake of every node
  input  logic [MESH_WIDTH*MESH_HEIGHT-1:0]          local_valid,
  input  logic [MESH_WIDTH*MESH_HEIGHT-1:0]          local_ready,
  input  flit_header_t [MESH_WIDTH*MESH_HEIGHT-1:0]  local_header,
  input  flit_payload_t [MESH_WIDTH*MESH_HEIGHT-1:0] local_payload,

  // Trace
  output logic                                       trace_valid,
  output trace_data_t                                trace_data,
  output node_id_t                                   trace_node_id
);

  localparam int NUM_NODES = MESH_WIDTH * MESH_HEIGHT;

  logic [NUM_NODES-1:0] deliver;
  logic                 sel_found;
  node_id_t             sel_node;
  trace_data_t          sel_data;

  assign deliver = local_valid & local_ready;

  // ==================================================
  // Priority select, lowest node number wins
  // ==================================================

  always_comb begin
    sel_found = 1'b0;
    sel_node  = '0;
    sel_data  = '0;
    for (int i = 0; i < NUM_NODES; i++) begin
      if (deliver[i] && !sel_found) begin
        sel_found = 1'b1;
        sel_node  = node_id_t'(i);
        // Header in the upper word, payload below
        sel_data  = {local_header[i], local_payload[i]};
      end
    end
  end

  // ==================================================
  // Trace registers
  // ==================================================

  // One pulse per cycle with any delivery
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      trace_valid <= 1'b0;
    end else begin
      trace_valid <= sel_found;
    end
  end

  // Hold last captured word between pulses
  always_ff @(posedge clk) begin
    if (sel_found) begin
      trace_data    <= sel_data;
      trace_node_id <= sel_node;
    end
  end

endmodule

`default_nettype wire

// File: src/nebula_status_agg.sv
`timescale 1ns/100ps
`default_nettype none

module nebula_status_agg
  import nebula_pkg::*;
#(
  parameter int MESH_WIDTH  = 4,
  parameter int MESH_HEIGHT = 4,
  parameter bit ENABLE_AXI  = 1'b1,
  parameter bit ENABLE_CHI  = 1'b1
) (
  input  logic                                   clk,
  input  logic                                   rst_n,
  input  logic [MESH_WIDTH*MESH_HEIGHT-1:0]      router_error,
  input  logic [MESH_WIDTH*MESH_HEIGHT-1:0]      protocol_error,
  output status_word_t                           system_status,
  output status_word_t                           error_status
);

  localparam int NUM_NODES = MESH_WIDTH * MESH_HEIGHT;

  // Combined per-node flags, one cycle behind the inputs
  logic [NUM_NODES-1:0] node_err_q;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      node_err_q <= '0;
    end else begin
      node_err_q <= router_error | protocol_error;
    end
  end

  // Fixed identification and topology word
  assign system_status = {
    STATUS_MAGIC,
    4'h0,
    4'(MESH_HEIGHT),
    4'(MESH_WIDTH),
    1'b0,
    ENABLE_CHI,
    ENABLE_AXI,
    1'b1
  };

  // Bits 15 and 14 are live, bit 13 is the registered summary
  assign error_status = {
    16'h0000,
    |protocol_error,
    |router_error,
    |node_err_q,
    13'h0000
  };

endmodule

`default_nettype wire

// File: src/nebula_config_regs.sv
`timescale 1ns/100ps
`default_nettype none

module nebula_config_regs
  import nebula_pkg::*;
#(
  parameter int MESH_WIDTH  = 4,
  parameter int MESH_HEIGHT = 4,
  parameter bit ENABLE_AXI  = 1'b1,
  parameter bit ENABLE_CHI  = 1'b1
) (
  input  logic      clk,
  input  logic      rst_n,

  // Request
  input  logic      cfg_req_valid,
  output logic      cfg_req_ready,
  input  cfg_addr_t cfg_req_addr,
  input  cfg_data_t cfg_req_data,
  input  logic      cfg_req_write,

  // Response
  output logic      cfg_resp_valid,
  input  logic      cfg_resp_ready,
  output cfg_data_t cfg_resp_data,
  output logic      cfg_resp_error
);

  localparam int NUM_NODES = MESH_WIDTH * MESH_HEIGHT;

  cfg_data_t  regs [NUM_CFG_REGS];
  reg_index_t req_index;
  logic       req_accept;
  logic       req_ro;
  logic       wr_en;

  // Default contents of each register after reset
  function automatic cfg_data_t reset_value(input int idx);
    cfg_data_t val;
    val = '0;
    case (idx)
      REG_TOPOLOGY:   val = {16'h0000, 8'(MESH_HEIGHT), 8'(MESH_WIDTH)};
      REG_CHI_EN:     val = {31'h0, ENABLE_CHI};
      REG_AXI_EN:     val = {31'h0, ENABLE_AXI};
      REG_NODE_COUNT: val = cfg_data_t'(NUM_NODES);
      default:        val = '0;
    endcase
    return val;
  endfunction

  // ==================================================
  // Request decode
  // ==================================================

  // Only the low address bits select a register
  assign req_index = cfg_req_addr[$bits(reg_index_t)-1:0];
  assign req_ro    = (req_index < NUM_RO_REGS);

  // Single response slot, free once the current one is taken
  assign cfg_req_ready = !cfg_resp_valid || cfg_resp_ready;
  assign req_accept    = cfg_req_valid && cfg_req_ready;
  assign wr_en         = req_accept && cfg_req_write && !req_ro;

  // ==================================================
  // Register array
  // ==================================================

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < NUM_CFG_REGS; i++) begin
        regs[i] <= reset_value(i);
      end
    end else if (wr_en) begin
      regs[req_index] <= cfg_req_data;
    end
  end

  // ==================================================
  // Response
  // ==================================================

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      cfg_resp_valid <= 1'b0;
      cfg_resp_error <= 1'b0;
    end else if (req_accept) begin
      cfg_resp_valid <= 1'b1;
      // Error only for writes into the read-only window
      cfg_resp_error <= cfg_req_write && req_ro;
    end else if (cfg_resp_ready) begin
      cfg_resp_valid <= 1'b0;
    end
  end

  // Writes answer with zero data, reads with the addressed word
  always_ff @(posedge clk) begin
    if (req_accept) begin
      if (cfg_req_write) begin
        cfg_resp_data <= '0;
      end else begin
        cfg_resp_data <= regs[req_index];
      end
    end
  end

endmodule

`default_nettype wire

// File: src/nebula_pkg.sv
`default_nettype none

package nebula_pkg;

  // ==================================================
  // Vector types
  // ==================================================

  // Configuration port
  typedef logic [15:0] cfg_addr_t;
  typedef logic [31:0] cfg_data_t;
  typedef logic [7:0]  reg_index_t;

  // Status words
  typedef logic [31:0] status_word_t;

  // Local-port flit fields and the trace word built from them
  typedef logic [31:0] flit_header_t;
  typedef logic [31:0] flit_payload_t;
  typedef logic [63:0] trace_data_t;
  typedef logic [7:0]  node_id_t;

  // ==================================================
  // Register map
  // ==================================================

  localparam int NUM_CFG_REGS = 256;

  // Indices below this bound are read-only
  localparam int NUM_RO_REGS = 16;

  // Topology defaults inside the read-only window
  localparam int REG_TOPOLOGY   = 0;
  localparam int REG_CHI_EN     = 1;
  localparam int REG_AXI_EN     = 2;
  localparam int REG_NODE_COUNT = 3;

  // Identification value in the top half of system status
  localparam logic [15:0] STATUS_MAGIC = 16'h5A5A;

endpackage

`default_nettype wire
